/* hdl/i2c_bit_fsm.sv */
// I2C bus phase sequencer
`timescale 1ns/1ps

module i2c_bit_fsm (
  input  logic          wb_clk_i,
  input  logic          arst_i,
  input  logic          cmd_valid_i,
  input  i2c_pkg::cmd_t cmd_i,
  input  logic          en_i,
  input  logic          tick_i,
  input  logic          last_bit_i,
  input  logic          tx_bit_i,
  input  logic          sda_pad_i,
  output logic          tick_en_o,
  output logic          shift_o,
  output logic          scl_drive_o,
  output logic          sda_drive_o,
  output logic          xfer_done_o,
  output logic          rx_ack_o,
  output logic          busy_o
);
  import i2c_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_ACK,
    ST_STOP
  } state_t;

  state_t     state_q;
  logic [1:0] qcnt_q;
  cmd_t       cmd_q;

  assign tick_en_o = (state_q != ST_IDLE);
  // Data is sampled and shifted in the second high-SCL quarter
  assign shift_o   = tick_i && en_i && (state_q == ST_DATA) && (qcnt_q == 2'd2);

  always_ff @(posedge wb_clk_i) begin
    if (cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q     <= ST_IDLE;
      qcnt_q      <= 2'd0;
      scl_drive_o <= 1'b0;
      sda_drive_o <= 1'b0;
      xfer_done_o <= 1'b0;
      rx_ack_o    <= 1'b0;
      busy_o      <= 1'b0;
    end else begin
      xfer_done_o <= 1'b0;
      if (!en_i) begin
        state_q     <= ST_IDLE;
        qcnt_q      <= 2'd0;
        scl_drive_o <= 1'b0;
        sda_drive_o <= 1'b0;
        busy_o      <= 1'b0;
      end else if (state_q == ST_IDLE) begin
        qcnt_q <= 2'd0;
        if (cmd_valid_i) begin
          if (cmd_i.sta) begin
            state_q <= ST_START;
          end else if (cmd_i.rd || cmd_i.wr) begin
            state_q <= ST_DATA;
          end else if (cmd_i.sto) begin
            state_q <= ST_STOP;
          end
        end
      end else if (tick_i) begin
        qcnt_q <= qcnt_q + 2'd1;
        case (state_q)
          // SCL is left as it was in the first quarter, for a repeated start
          ST_START: begin
            if (qcnt_q == 2'd0) sda_drive_o <= 1'b0;
            if (qcnt_q == 2'd1) scl_drive_o <= 1'b0;
            if (qcnt_q == 2'd2) begin
              sda_drive_o <= 1'b1;
              busy_o      <= 1'b1;
            end
            if (qcnt_q == 2'd3) begin
              scl_drive_o <= 1'b1;
              state_q     <= ST_DATA;
            end
          end
          ST_DATA: begin
            if (qcnt_q == 2'd0) begin
              scl_drive_o <= 1'b1;
              sda_drive_o <= !cmd_q.rd && !tx_bit_i;
            end
            if (qcnt_q == 2'd1) scl_drive_o <= 1'b0;
            if (qcnt_q == 2'd3) begin
              scl_drive_o <= 1'b1;
              if (last_bit_i) state_q <= ST_ACK;
            end
          end
          ST_ACK: begin
            if (qcnt_q == 2'd0) begin
              scl_drive_o <= 1'b1;
              // Master acknowledge only on reads
              sda_drive_o <= cmd_q.rd && !cmd_q.ack;
            end
            if (qcnt_q == 2'd1) scl_drive_o <= 1'b0;
            if (qcnt_q == 2'd2) rx_ack_o <= sda_pad_i;
            if (qcnt_q == 2'd3) begin
              scl_drive_o <= 1'b1;
              if (cmd_q.sto) begin
                state_q <= ST_STOP;
              end else begin
                state_q     <= ST_IDLE;
                xfer_done_o <= 1'b1;
              end
            end
          end
          ST_STOP: begin
            if (qcnt_q == 2'd0) begin
              scl_drive_o <= 1'b1;
              sda_drive_o <= 1'b1;
            end
            if (qcnt_q == 2'd1) scl_drive_o <= 1'b0;
            if (qcnt_q == 2'd2) sda_drive_o <= 1'b0;
            if (qcnt_q == 2'd3) begin
              state_q     <= ST_IDLE;
              busy_o      <= 1'b0;
              xfer_done_o <= 1'b1;
            end
          end
          default: state_q <= ST_IDLE;
        endcase
      end
    end
  end

  // SDA moves only under a low SCL outside start and stop
  a_sda_scl_low: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    ($changed(sda_drive_o) && en_i && !(state_q inside {ST_START, ST_STOP}))
      |-> (scl_drive_o && $past(scl_drive_o)));

endmodule

/* hdl/i2c_master_top.sv */
// Wishbone I2C master
`timescale 1ns/1ps

module i2c_master_top #(
  parameter logic [i2c_pkg::PRER_W-1:0] PRER_RESET = '1
) (
  input  logic             wb_clk_i,
  input  logic             arst_i,
  input  i2c_pkg::wb_req_t wb_req_i,
  output logic [7:0]       wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_inta_o,
  input  logic             sda_pad_i,
  output logic             scl_drive_o,
  output logic             sda_drive_o
);
  import i2c_pkg::*;

  cmd_t              cmd;
  i2c_byte_u         tx_byte;
  logic [PRER_W-1:0] prer;
  logic [7:0]        rx_byte;
  logic              cmd_valid;
  logic              en;
  logic              tick;
  logic              tick_en;
  logic              shift;
  logic              tx_bit;
  logic              last_bit;
  logic              xfer_done;
  logic              rx_ack;
  logic              busy;

  i2c_wb_regs #(
    .PRER_RESET (PRER_RESET)
  ) i2c_wb_regs_inst (
    .wb_clk_i    (wb_clk_i),
    .arst_i      (arst_i),
    .wb_req_i    (wb_req_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_inta_o   (wb_inta_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .prer_o      (prer),
    .tx_byte_o   (tx_byte),
    .rx_byte_i   (rx_byte),
    .xfer_done_i (xfer_done),
    .rx_ack_i    (rx_ack),
    .busy_i      (busy),
    .en_o        (en)
  );

  i2c_prescale_timer i2c_prescale_timer_inst (
    .wb_clk_i  (wb_clk_i),
    .arst_i    (arst_i),
    .tick_en_i (tick_en),
    .prer_i    (prer),
    .tick_o    (tick)
  );

  i2c_bit_fsm i2c_bit_fsm_inst (
    .wb_clk_i    (wb_clk_i),
    .arst_i      (arst_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .en_i        (en),
    .tick_i      (tick),
    .last_bit_i  (last_bit),
    .tx_bit_i    (tx_bit),
    .sda_pad_i   (sda_pad_i),
    .tick_en_o   (tick_en),
    .shift_o     (shift),
    .scl_drive_o (scl_drive_o),
    .sda_drive_o (sda_drive_o),
    .xfer_done_o (xfer_done),
    .rx_ack_o    (rx_ack),
    .busy_o      (busy)
  );

  i2c_shift_reg i2c_shift_reg_inst (
    .wb_clk_i    (wb_clk_i),
    .arst_i      (arst_i),
    .load_i      (cmd_valid),
    .load_byte_i (tx_byte),
    .shift_i     (shift),
    .sda_in_i    (sda_pad_i),
    .tx_bit_o    (tx_bit),
    .rx_byte_o   (rx_byte),
    .last_bit_o  (last_bit)
  );

endmodule

/* hdl/i2c_pkg.sv */
// I2C master shared definitions
package i2c_pkg;

  // Prescale counter width
  localparam int PRER_W = 16;

  // Register map
  localparam logic [2:0] ADR_PRER_LO = 3'd0;
  localparam logic [2:0] ADR_PRER_HI = 3'd1;
  localparam logic [2:0] ADR_CTR     = 3'd2;
  localparam logic [2:0] ADR_TXRX    = 3'd3;
  localparam logic [2:0] ADR_CRSR    = 3'd4;

  // Command register layout, STA down to ACK sit in [7:3]
  localparam int CMD_LSB     = 3;
  localparam int CR_IACK_BIT = 0;

  // Only EN and IEN are writable
  localparam logic [7:0] CTR_MASK = 8'hC0;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [2:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic       en;
    logic       ien;
    logic [5:0] rsvd;
  } ctr_t;

  typedef struct packed {
    logic sta;
    logic sto;
    logic rd;
    logic wr;
    logic ack;
  } cmd_t;

  typedef struct packed {
    logic       rx_ack;
    logic       busy;
    logic [3:0] rsvd;
    logic       tip;
    logic       irq_flag;
  } status_t;

  // Transmit byte, plain data or slave address plus R/W
  typedef union packed {
    logic [7:0] data;
    struct packed {
      logic [6:0] addr;
      logic       rw;
    } addr_rw;
  } i2c_byte_u;

endpackage

/* hdl/i2c_prescale_timer.sv */
// Quarter-bit tick generator
`timescale 1ns/1ps

module i2c_prescale_timer (
  input  logic                       wb_clk_i,
  input  logic                       arst_i,
  input  logic                       tick_en_i,
  input  logic [i2c_pkg::PRER_W-1:0] prer_i,
  output logic                       tick_o
);
  import i2c_pkg::*;

  logic [PRER_W-1:0] cnt_q;

  // One tick every PRER+1 clocks
  assign tick_o = tick_en_i && (cnt_q == '0);

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      cnt_q <= '0;
    end else if (!tick_en_i || cnt_q == '0) begin
      cnt_q <= prer_i;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  a_no_idle_tick: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    !tick_en_i |-> !tick_o);

endmodule

/* hdl/i2c_shift_reg.sv */
// Transmit and receive byte shifter
`timescale 1ns/1ps

module i2c_shift_reg (
  input  logic               wb_clk_i,
  input  logic               arst_i,
  input  logic               load_i,
  input  i2c_pkg::i2c_byte_u load_byte_i,
  input  logic               shift_i,
  input  logic               sda_in_i,
  output logic               tx_bit_o,
  output logic [7:0]         rx_byte_o,
  output logic               last_bit_o
);

  logic [7:0] data_q;
  logic [2:0] cnt_q;

  // MSB first out, sampled bit in at the bottom
  assign tx_bit_o  = data_q[7];
  assign rx_byte_o = data_q;

  always_ff @(posedge wb_clk_i) begin
    if (load_i) begin
      data_q <= load_byte_i.data;
    end else if (shift_i) begin
      data_q <= {data_q[6:0], sda_in_i};
    end
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      cnt_q      <= 3'd0;
      last_bit_o <= 1'b0;
    end else if (load_i) begin
      cnt_q      <= 3'd0;
      last_bit_o <= 1'b0;
    end else if (shift_i) begin
      cnt_q <= cnt_q + 3'd1;
      // Eighth shift
      if (cnt_q == 3'd7) begin
        last_bit_o <= 1'b1;
      end
    end
  end

endmodule

/* hdl/i2c_wb_regs.sv */
// Wishbone register file
`timescale 1ns/1ps

module i2c_wb_regs #(
  parameter logic [i2c_pkg::PRER_W-1:0] PRER_RESET = '1
) (
  input  logic                       wb_clk_i,
  input  logic                       arst_i,
  input  i2c_pkg::wb_req_t           wb_req_i,
  output logic [7:0]                 wb_dat_o,
  output logic                       wb_ack_o,
  output logic                       wb_inta_o,
  output logic                       cmd_valid_o,
  output i2c_pkg::cmd_t              cmd_o,
  output logic [i2c_pkg::PRER_W-1:0] prer_o,
  output i2c_pkg::i2c_byte_u         tx_byte_o,
  input  logic [7:0]                 rx_byte_i,
  input  logic                       xfer_done_i,
  input  logic                       rx_ack_i,
  input  logic                       busy_i,
  output logic                       en_o
);
  import i2c_pkg::*;

  ctr_t       ctr_q;
  status_t    status;
  cmd_t       cmd_w;
  logic       tip_q;
  logic       irq_flag_q;
  logic       rx_ack_q;
  logic       req_seen;
  logic       wr_acc;
  logic       cmd_wr;
  logic       cmd_start;
  logic       iack;
  logic [7:0] rd_data;

  assign req_seen = wb_req_i.cyc & wb_req_i.stb;
  // Writes take effect in the ack cycle
  assign wr_acc   = req_seen & wb_req_i.we & wb_ack_o;
  assign cmd_wr   = wr_acc & (wb_req_i.adr == ADR_CRSR);
  assign cmd_w    = cmd_t'(wb_req_i.dat[7:CMD_LSB]);
  assign iack     = cmd_wr & wb_req_i.dat[CR_IACK_BIT];

  // Commands during a transfer are dropped
  assign cmd_start = cmd_wr & ctr_q.en & ~tip_q &
                     (cmd_w.sta | cmd_w.sto | cmd_w.rd | cmd_w.wr);

  assign en_o = ctr_q.en;

  assign status = '{rx_ack: rx_ack_q, busy: busy_i, rsvd: 4'b0000,
                    tip: tip_q, irq_flag: irq_flag_q};

  always_comb begin
    case (wb_req_i.adr)
      ADR_PRER_LO: rd_data = prer_o[7:0];
      ADR_PRER_HI: rd_data = prer_o[PRER_W-1:8];
      ADR_CTR:     rd_data = ctr_q;
      ADR_TXRX:    rd_data = rx_byte_i;
      ADR_CRSR:    rd_data = status;
      default:     rd_data = 8'h00;
    endcase
  end

  // Single ack per held request
  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req_seen & ~wb_ack_o;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    wb_dat_o <= rd_data;
    cmd_o    <= cmd_w;
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      prer_o      <= PRER_RESET;
      ctr_q       <= '0;
      tx_byte_o   <= '0;
      cmd_valid_o <= 1'b0;
      tip_q       <= 1'b0;
      irq_flag_q  <= 1'b0;
      rx_ack_q    <= 1'b0;
      wb_inta_o   <= 1'b0;
    end else begin
      cmd_valid_o <= cmd_start;

      if (wr_acc) begin
        case (wb_req_i.adr)
          ADR_PRER_LO: if (!ctr_q.en) prer_o[7:0] <= wb_req_i.dat;
          ADR_PRER_HI: if (!ctr_q.en) prer_o[PRER_W-1:8] <= wb_req_i.dat;
          ADR_CTR:     ctr_q <= ctr_t'(wb_req_i.dat & CTR_MASK);
          ADR_TXRX:    tx_byte_o.data <= wb_req_i.dat;
          default:     ;
        endcase
      end

      if (cmd_valid_o) begin
        tip_q <= 1'b1;
      end else if (xfer_done_i || !ctr_q.en) begin
        tip_q <= 1'b0;
      end

      // A completing transfer wins over IACK
      if (xfer_done_i) begin
        irq_flag_q <= 1'b1;
        rx_ack_q   <= rx_ack_i;
      end else if (iack) begin
        irq_flag_q <= 1'b0;
      end

      wb_inta_o <= ctr_q.ien & irq_flag_q;
    end
  end

  a_ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    wb_ack_o |=> !wb_ack_o);

  a_no_cmd_in_tip: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    cmd_valid_o |-> !tip_q);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module i2c_master_tb -o i2c_master_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/i2c_master_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
fi
exit 1

/* sources.f */
hdl/i2c_pkg.sv
hdl/i2c_wb_regs.sv
hdl/i2c_prescale_timer.sv
hdl/i2c_bit_fsm.sv
hdl/i2c_shift_reg.sv
hdl/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_master_tb.sv

/* verification/i2c_master_tb.sv */
// I2C master directed testbench
`timescale 1ns/1ps

module i2c_master_tb;
  import i2c_pkg::*;

  localparam int         ACK_TIMEOUT = 16;
  localparam int         IRQ_POLLS   = 500;
  localparam logic [6:0] SLAVE_ADDR  = 7'h51;

  logic        wb_clk_i;
  logic        arst_i;
  wb_req_t     wb_req;
  logic [7:0]  wb_dat;
  logic        wb_ack;
  logic        wb_inta;
  logic        scl_drive;
  logic        sda_drive;
  logic        sda_line;
  logic [7:0]  slave_tx;
  logic [7:0]  slave_rx;
  logic        slave_master_ack;
  logic [31:0] lfsr;
  int          err_count;
  int          test_count;
  int          test_fails;

  i2c_master_top i2c_master_top_inst (
    .wb_clk_i    (wb_clk_i),
    .arst_i      (arst_i),
    .wb_req_i    (wb_req),
    .wb_dat_o    (wb_dat),
    .wb_ack_o    (wb_ack),
    .wb_inta_o   (wb_inta),
    .sda_pad_i   (sda_line),
    .scl_drive_o (scl_drive),
    .sda_drive_o (sda_drive)
  );

  i2c_slave_model #(
    .ADDR (SLAVE_ADDR)
  ) i2c_slave_model_inst (
    .scl_drive_i  (scl_drive),
    .sda_drive_i  (sda_drive),
    .tx_byte_i    (slave_tx),
    .sda_o        (sda_line),
    .rx_byte_o    (slave_rx),
    .master_ack_o (slave_master_ack)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic lfsr_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] cmd_byte(input cmd_t c, input logic iack);
    logic [7:0] b;
    b                 = 8'h00;
    b[CMD_LSB +: 5]   = c;
    b[CR_IACK_BIT]    = iack;
    return b;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      err_count++;
      $display("ERR %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      err_count++;
      $display("ERR %s: expected status %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("ERR %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      test_fails++;
      $display("test %s: %0d check(s) failed", name, err_count - errs_before);
    end
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [7:0] dat);
    int n;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    n = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end while (!wb_ack && n < ACK_TIMEOUT);
    if (!wb_ack) begin
      err_count++;
      $display("write to register %0d was never acknowledged", adr);
    end
    // The write lands on the edge after the ack cycle
    @(posedge wb_clk_i);
    #1;
    wb_req = '0;
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [7:0] dat);
    int n;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
    n = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end while (!wb_ack && n < ACK_TIMEOUT);
    dat = wb_dat;
    if (!wb_ack) begin
      err_count++;
      $display("read of register %0d was never acknowledged", adr);
    end
    @(posedge wb_clk_i);
    #1;
    wb_req = '0;
  endtask

  task automatic wait_irq(input string name, output status_t st);
    int         n;
    logic [7:0] d;
    n = 0;
    do begin
      wb_read(ADR_CRSR, d);
      st = status_t'(d);
      n++;
    end while (!st.irq_flag && n < IRQ_POLLS);
    if (!st.irq_flag) begin
      err_count++;
      $display("%s: transfer never set the interrupt flag", name);
    end
  endtask

  task automatic test_reset_values();
    int         errs;
    logic [7:0] d;
    errs = err_count;
    check_bit("reset ack", 1'b0, wb_ack);
    check_bit("reset scl drive", 1'b0, scl_drive);
    check_bit("reset sda drive", 1'b0, sda_drive);
    wb_read(ADR_PRER_LO, d);
    check_byte("reset prer_lo", 8'hFF, d);
    wb_read(ADR_PRER_HI, d);
    check_byte("reset prer_hi", 8'hFF, d);
    wb_read(ADR_CTR, d);
    check_byte("reset ctr", 8'h00, d);
    wb_read(ADR_CRSR, d);
    check_status("reset status", status_t'(8'h00), status_t'(d));
    check_bit("reset inta", 1'b0, wb_inta);
    report_test("reset_values", errs);
  endtask

  task automatic test_register_rules();
    int         errs;
    logic [7:0] d;
    errs = err_count;
    wb_write(ADR_PRER_LO, 8'h5A);
    wb_write(ADR_PRER_HI, 8'hA5);
    wb_read(ADR_PRER_LO, d);
    check_byte("prer_lo write", 8'h5A, d);
    wb_read(ADR_PRER_HI, d);
    check_byte("prer_hi write", 8'hA5, d);
    wb_write(ADR_CTR, 8'h80);
    wb_write(ADR_PRER_LO, 8'h11);
    wb_read(ADR_PRER_LO, d);
    check_byte("prer_lo while enabled", 8'h5A, d);
    wb_write(ADR_CTR, 8'hFF);
    wb_read(ADR_CTR, d);
    check_byte("ctr reserved bits", 8'hC0, d);
    // No transfer starts while the core is disabled
    wb_write(ADR_CTR, 8'h00);
    wb_write(ADR_CRSR, cmd_byte(cmd_t'('1), 1'b0));
    wb_read(ADR_CRSR, d);
    check_status("command readback", status_t'(8'h00), status_t'(d));
    report_test("register_rules", errs);
  endtask

  task automatic test_addressed_write();
    int        errs;
    i2c_byte_u tx;
    status_t   st;
    errs = err_count;
    tx.addr_rw.addr = SLAVE_ADDR;
    tx.addr_rw.rw   = 1'b0;
    wb_write(ADR_CTR, 8'hC0);
    wb_write(ADR_TXRX, tx.data);
    wb_write(ADR_CRSR, cmd_byte('{sta: 1'b1, sto: 1'b0, rd: 1'b0, wr: 1'b1, ack: 1'b0}, 1'b1));
    wait_irq("addressed_write", st);
    check_status("addressed write status",
                 '{rx_ack: 1'b0, busy: 1'b1, rsvd: 4'h0, tip: 1'b0, irq_flag: 1'b1}, st);
    check_byte("slave address byte", tx.data, slave_rx);
    check_bit("interrupt output", 1'b1, wb_inta);
    report_test("addressed_write", errs);
  endtask

  task automatic test_wrong_address();
    int        errs;
    i2c_byte_u tx;
    status_t   st;
    errs = err_count;
    tx.addr_rw.addr = 7'h22;
    tx.addr_rw.rw   = 1'b0;
    wb_write(ADR_TXRX, tx.data);
    wb_write(ADR_CRSR, cmd_byte('{sta: 1'b1, sto: 1'b0, rd: 1'b0, wr: 1'b1, ack: 1'b0}, 1'b1));
    wait_irq("wrong_address", st);
    check_status("wrong address status",
                 '{rx_ack: 1'b1, busy: 1'b1, rsvd: 4'h0, tip: 1'b0, irq_flag: 1'b1}, st);
    check_byte("slave saw wrong address", tx.data, slave_rx);
    wb_write(ADR_CRSR, cmd_byte('{sta: 1'b0, sto: 1'b1, rd: 1'b0, wr: 1'b0, ack: 1'b0}, 1'b1));
    wait_irq("wrong_address stop", st);
    check_bit("stop clears busy", 1'b0, st.busy);
    report_test("wrong_address", errs);
  endtask

  task automatic test_read_nack_stop();
    int         errs;
    i2c_byte_u  tx;
    status_t    st;
    logic [7:0] exp_byte;
    logic [7:0] d;
    errs = err_count;
    lfsr_byte(exp_byte);
    slave_tx        = exp_byte;
    tx.addr_rw.addr = SLAVE_ADDR;
    tx.addr_rw.rw   = 1'b1;
    wb_write(ADR_TXRX, tx.data);
    wb_write(ADR_CRSR, cmd_byte('{sta: 1'b1, sto: 1'b0, rd: 1'b0, wr: 1'b1, ack: 1'b0}, 1'b1));
    wait_irq("read address", st);
    check_bit("read address acked", 1'b0, st.rx_ack);
    wb_write(ADR_CRSR, cmd_byte('{sta: 1'b0, sto: 1'b1, rd: 1'b1, wr: 1'b0, ack: 1'b1}, 1'b1));
    wait_irq("read data", st);
    check_bit("busy after read stop", 1'b0, st.busy);
    wb_read(ADR_TXRX, d);
    check_byte("read data", exp_byte, d);
    check_bit("master ack level", 1'b1, slave_master_ack);
    report_test("read_nack_stop", errs);
  endtask

  task automatic test_iack_only();
    int         errs;
    logic [7:0] d;
    status_t    st;
    errs = err_count;
    check_bit("inta before iack", 1'b1, wb_inta);
    wb_write(ADR_CRSR, cmd_byte('0, 1'b1));
    // Second read sees tip if a transfer had started
    wb_read(ADR_CRSR, d);
    wb_read(ADR_CRSR, d);
    st = status_t'(d);
    check_bit("iack clears flag", 1'b0, st.irq_flag);
    check_bit("iack starts nothing", 1'b0, st.tip);
    check_bit("iack drops inta", 1'b0, wb_inta);
    check_bit("scl left released", 1'b0, scl_drive);
    check_bit("sda left released", 1'b0, sda_drive);
    report_test("iack_only", errs);
  endtask

  initial begin
    arst_i     = 1'b1;
    wb_req     = '0;
    slave_tx   = 8'h00;
    lfsr       = 32'he853;
    err_count  = 0;
    test_count = 0;
    test_fails = 0;
    repeat (16) @(posedge wb_clk_i);
    #1;
    arst_i = 1'b0;

    test_reset_values();
    test_register_rules();
    wb_write(ADR_PRER_LO, 8'd3);
    wb_write(ADR_PRER_HI, 8'd0);
    test_addressed_write();
    test_wrong_address();
    test_read_nack_stop();
    test_iack_only();

    $display("summary: %0d tests, %0d failed, %0d check errors",
             test_count, test_fails, err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verification/i2c_slave_model.sv */
// Behavioral I2C slave
`timescale 1ns/1ps

module i2c_slave_model #(
  parameter logic [6:0] ADDR = 7'h51
) (
  input  logic       scl_drive_i,
  input  logic       sda_drive_i,
  input  logic [7:0] tx_byte_i,
  output logic       sda_o,
  output logic [7:0] rx_byte_o,
  output logic       master_ack_o
);
  import i2c_pkg::*;

  logic       scl;
  logic       sda;
  logic       sda_pull   = 1'b0;
  logic       scl_q      = 1'b1;
  logic       sda_q      = 1'b1;
  logic       active     = 1'b0;
  logic       is_addr    = 1'b0;
  logic       reading    = 1'b0;
  logic [3:0] bit_cnt    = 4'd0;
  logic [7:0] shreg      = 8'h00;
  logic [7:0] rx_byte    = 8'h00;
  logic       master_ack = 1'b0;
  i2c_byte_u  rx_view;

  // Pull-ups hold a line high unless either side drives it low
  assign scl          = ~scl_drive_i;
  assign sda          = ~(sda_drive_i | sda_pull);
  assign sda_o        = sda;
  assign rx_byte_o    = rx_byte;
  assign master_ack_o = master_ack;

  always @(scl or sda) begin
    if (scl && scl_q && sda_q && !sda) begin
      // Start or repeated start
      active   = 1'b1;
      is_addr  = 1'b1;
      reading  = 1'b0;
      bit_cnt  = 4'd0;
      sda_pull = 1'b0;
    end else if (scl && scl_q && !sda_q && sda) begin
      active   = 1'b0;
      sda_pull = 1'b0;
    end else if (active && scl && !scl_q) begin
      if (bit_cnt < 4'd8) begin
        if (!reading) shreg = {shreg[6:0], sda};
      end else if (reading && !is_addr) begin
        master_ack = sda;
      end
      bit_cnt = bit_cnt + 4'd1;
    end else if (active && !scl && scl_q) begin
      if (bit_cnt == 4'd8) begin
        if (reading) begin
          sda_pull = 1'b0;
        end else begin
          rx_byte      = shreg;
          rx_view.data = shreg;
          if (is_addr && rx_view.addr_rw.addr != ADDR) begin
            active = 1'b0;
          end else begin
            sda_pull = 1'b1;
            if (is_addr) reading = rx_view.addr_rw.rw;
          end
        end
      end else if (bit_cnt == 4'd9) begin
        bit_cnt  = 4'd0;
        sda_pull = 1'b0;
        // Next byte only after an address or a master ACK
        if (reading && (is_addr || !master_ack)) begin
          shreg    = tx_byte_i;
          sda_pull = ~shreg[7];
        end else if (reading) begin
          active = 1'b0;
        end
        is_addr = 1'b0;
      end else if (reading && bit_cnt != 4'd0) begin
        shreg    = {shreg[6:0], 1'b0};
        sda_pull = ~shreg[7];
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule
